//--- include/calc_settings.svh
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

// Datapath widths
`define CALC_WIDTH  16
`define DIGIT_WIDTH 4
`define OP_WIDTH    3

// One-hot operator codes from the keypad
`define OP_ADD 3'b001
`define OP_SUB 3'b010
`define OP_MUL 3'b100

`define MULT_ITER `CALC_WIDTH      // One shift-and-add step per multiplier bit

`endif

//--- verilog/calc_pkg.sv
`default_nettype none
`include "calc_settings.svh"

package calc_pkg;

    // All arithmetic is unsigned and wraps at the operand width
    typedef logic [`CALC_WIDTH-1:0] operand_t;      // Operands, results, worker inputs

    typedef logic [`DIGIT_WIDTH-1:0] digit_t;       // Single decimal keypad digit

    typedef logic [`OP_WIDTH-1:0] op_code_t;        // One-hot add/sub/mul code

endpackage

`default_nettype wire

//--- verilog/add_sub_unit.sv
`default_nettype none

module add_sub_unit (
    input  wire                     clk,
    input  wire                     nRST,
    input  wire calc_pkg::operand_t a,
    input  wire calc_pkg::operand_t b,
    input  wire                     sub,        // 1 selects a minus b
    input  wire                     start,
    output calc_pkg::operand_t      result,
    output logic                    finish
);

    // Handshake flag
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;                    // Done one cycle after start
        end
    end

    // Result wraps at the operand width
    always_ff @(posedge clk) begin
        if (start) begin
            if (sub) begin
                result <= a - b;
            end else begin
                result <= a + b;
            end
        end
    end

    // One item in flight means start never lasts two cycles
    start_single_pulse: assert property (@(posedge clk) disable iff (!nRST)
        start |=> !start);

endmodule

`default_nettype wire

//--- verilog/seq_multiplier.sv
`default_nettype none
`include "calc_settings.svh"

module seq_multiplier (
    input  wire                     clk,
    input  wire                     nRST,
    input  wire calc_pkg::operand_t a,
    input  wire calc_pkg::operand_t b,
    input  wire                     start,
    output calc_pkg::operand_t      result,
    output logic                    finish
);

    localparam int CNT_W = $clog2(`MULT_ITER);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   count;                  // Iteration index
    calc_pkg::operand_t mcand;                  // Shifts left each step
    calc_pkg::operand_t mplier;                 // Shifts right each step
    calc_pkg::operand_t product;                // Low half of the product

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ST_IDLE;
            count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        count <= '0;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`MULT_ITER - 1)) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;           // Finish lasts one cycle
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand   <= a;
            mplier  <= b;
            product <= '0;
        end else if (state == ST_RUN) begin
            if (mplier[0]) begin
                product <= product + mcand;     // Carries past bit 15 drop out
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = product;
    assign finish = (state == ST_DONE);

    // Controller keeps one multiplication in flight at a time
    no_start_while_busy: assert property (@(posedge clk) disable iff (!nRST)
        (state != ST_IDLE) |-> !start);

endmodule

`default_nettype wire

//--- verilog/calc_control.sv
`default_nettype none
`include "calc_settings.svh"

module calc_control (
    input  wire                     clk,
    input  wire                     nRST,
    input  wire calc_pkg::digit_t   keypad_input,
    input  wire                     read_input,
    input  wire calc_pkg::op_code_t operator_input,
    input  wire                     equal_input,
    input  wire calc_pkg::operand_t add_result,
    input  wire                     add_finish,
    input  wire calc_pkg::operand_t mul_result,
    input  wire                     mul_finish,
    output logic                    busy,
    output logic                    complete,
    output calc_pkg::operand_t      display_output,
    output calc_pkg::operand_t      add_a,
    output calc_pkg::operand_t      add_b,
    output logic                    add_sub,
    output logic                    add_start,
    output calc_pkg::operand_t      mul_a,
    output calc_pkg::operand_t      mul_b,
    output logic                    mul_start
);

    typedef enum logic [2:0] {
        ST_IDLE_FIRST,                      // Keying first operand
        ST_SCALE,                           // Operand times ten on the multiplier
        ST_ACCUMULATE,                      // Scaled operand plus digit on the adder
        ST_IDLE_SECOND,                     // Keying second operand
        ST_DISPATCH,                        // Start the selected worker
        ST_WAIT,                            // Wait for the worker result
        ST_SHOW                             // Result on display, complete held
    } state_t;

    state_t             state;
    calc_pkg::operand_t operand_a;
    calc_pkg::operand_t operand_b;
    calc_pkg::operand_t entry_operand;
    calc_pkg::digit_t   digit_reg;          // Digit being folded in
    calc_pkg::op_code_t op_reg;             // Latched operator
    logic               second_entry;       // Digits go to operand_b
    logic               issued;             // Start already sent in this state
    logic               op_valid;

    assign entry_operand = second_entry ? operand_b : operand_a;

    assign op_valid = (operator_input == `OP_ADD) ||
                      (operator_input == `OP_SUB) ||
                      (operator_input == `OP_MUL);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ST_IDLE_FIRST;
            operand_a      <= '0;
            operand_b      <= '0;
            digit_reg      <= '0;
            op_reg         <= '0;
            second_entry   <= 1'b0;
            issued         <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            case (state)
                ST_IDLE_FIRST: begin
                    if (read_input) begin           // Digit wins over operator
                        digit_reg <= keypad_input;
                        state     <= ST_SCALE;
                    end else if (op_valid) begin
                        op_reg       <= operator_input;
                        second_entry <= 1'b1;
                        state        <= ST_IDLE_SECOND;
                    end
                end
                ST_SCALE: begin
                    issued <= 1'b1;
                    if (mul_finish) begin
                        issued <= 1'b0;
                        if (second_entry) begin
                            operand_b <= mul_result;
                        end else begin
                            operand_a <= mul_result;
                        end
                        state <= ST_ACCUMULATE;
                    end
                end
                ST_ACCUMULATE: begin
                    issued <= 1'b1;
                    if (add_finish) begin
                        issued <= 1'b0;
                        if (second_entry) begin
                            operand_b <= add_result;
                            state     <= ST_IDLE_SECOND;
                        end else begin
                            operand_a <= add_result;
                            state     <= ST_IDLE_FIRST;
                        end
                    end
                end
                ST_IDLE_SECOND: begin
                    if (read_input) begin
                        digit_reg <= keypad_input;
                        state     <= ST_SCALE;
                    end else if (equal_input) begin
                        state <= ST_DISPATCH;
                    end
                end
                ST_DISPATCH: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    // Only the dispatched worker can finish here
                    if (add_finish || mul_finish) begin
                        display_output <= mul_finish ? mul_result : add_result;
                        complete       <= 1'b1;
                        state          <= ST_SHOW;
                    end
                end
                ST_SHOW: begin
                    if (read_input) begin           // New calculation from zero
                        digit_reg    <= keypad_input;
                        operand_a    <= '0;
                        operand_b    <= '0;
                        second_entry <= 1'b0;
                        complete     <= 1'b0;
                        state        <= ST_SCALE;
                    end
                end
                default: begin
                    state <= ST_IDLE_FIRST;
                end
            endcase
        end
    end

    // Worker operands and start pulses
    always_comb begin
        busy      = !((state == ST_IDLE_FIRST) || (state == ST_IDLE_SECOND) ||
                      (state == ST_SHOW));
        add_a     = entry_operand;
        add_b     = calc_pkg::operand_t'(digit_reg);     // Zero-extended digit
        add_sub   = 1'b0;
        add_start = 1'b0;
        mul_a     = entry_operand;
        mul_b     = calc_pkg::operand_t'(10);
        mul_start = 1'b0;
        case (state)
            ST_SCALE: begin
                mul_start = !issued;
            end
            ST_ACCUMULATE: begin
                add_start = !issued;
            end
            ST_DISPATCH: begin
                add_a     = operand_a;
                add_b     = operand_b;
                add_sub   = (op_reg == `OP_SUB);
                mul_a     = operand_a;
                mul_b     = operand_b;
                add_start = (op_reg != `OP_MUL);
                mul_start = (op_reg == `OP_MUL);
            end
            default: begin
            end
        endcase
    end

    // Each finish pulse belongs to the worker the FSM is waiting on
    mul_finish_expected: assert property (@(posedge clk) disable iff (!nRST)
        mul_finish |-> ((state == ST_SCALE) || (state == ST_WAIT && op_reg == `OP_MUL)));

    add_finish_expected: assert property (@(posedge clk) disable iff (!nRST)
        add_finish |-> ((state == ST_ACCUMULATE) || (state == ST_WAIT && op_reg != `OP_MUL)));

endmodule

`default_nettype wire

//--- verilog/calc_top.sv
`default_nettype none

module calc_top (
    input  wire                     clk,
    input  wire                     nRST,
    input  wire calc_pkg::digit_t   keypad_input,
    input  wire                     read_input,
    input  wire calc_pkg::op_code_t operator_input,
    input  wire                     equal_input,
    output logic                    busy,
    output logic                    complete,
    output calc_pkg::operand_t      display_output
);

    // Controller to adder/subtractor
    calc_pkg::operand_t add_a;
    calc_pkg::operand_t add_b;
    logic               add_sub;
    logic               add_start;
    calc_pkg::operand_t add_result;
    logic               add_finish;

    // Controller to multiplier
    calc_pkg::operand_t mul_a;
    calc_pkg::operand_t mul_b;
    logic               mul_start;
    calc_pkg::operand_t mul_result;
    logic               mul_finish;

    calc_control u_control (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output),
        .add_a          (add_a),
        .add_b          (add_b),
        .add_sub        (add_sub),
        .add_start      (add_start),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .mul_start      (mul_start)
    );

    add_sub_unit u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .a      (add_a),
        .b      (add_b),
        .sub    (add_sub),
        .start  (add_start),
        .result (add_result),
        .finish (add_finish)
    );

    seq_multiplier u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mul_a),
        .b      (mul_b),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

`default_nettype wire

//--- tb/calc_tb.sv
`default_nettype none
`include "calc_settings.svh"

module calc_tb;

    localparam int NUM_ROWS    = 10;
    localparam int FIXED_ROWS  = 7;
    localparam int HOLD_CYCLES = 4;                         // Idle cycles with complete held
    localparam int WAIT_LIMIT  = 4 * `MULT_ITER;            // Bound on a single handshake
    localparam int ROW_CYCLES  = 8 * (`MULT_ITER + 6) + `MULT_ITER + 10;
    localparam int RUN_LIMIT   = NUM_ROWS * (ROW_CYCLES + HOLD_CYCLES) + 100;

    logic               clk;
    logic               nRST;
    calc_pkg::digit_t   keypad_input;
    logic               read_input;
    calc_pkg::op_code_t operator_input;
    logic               equal_input;
    logic               busy;
    logic               complete;
    calc_pkg::operand_t display_output;

    // Stimulus table, operands packed one decimal digit per nibble
    int unsigned        a_len [NUM_ROWS];
    logic [15:0]        a_keys [NUM_ROWS];
    calc_pkg::op_code_t pre_op [NUM_ROWS];                  // Non one-hot code, 0 for none
    calc_pkg::op_code_t row_op [NUM_ROWS];
    int unsigned        b_len [NUM_ROWS];
    logic [15:0]        b_keys [NUM_ROWS];
    logic               busy_keys [NUM_ROWS];               // Extra digit while busy
    calc_pkg::operand_t expected [NUM_ROWS];

    int unsigned        errors;
    int unsigned        checks;
    int unsigned        cycle_count = 0;

    calc_top uut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RUN_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", RUN_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // Keyed digits folded as times ten plus digit, 16-bit wrap
    function automatic calc_pkg::operand_t key_value(input logic [15:0] keys,
                                                     input int unsigned len);
        calc_pkg::operand_t value;
        value = '0;
        for (int i = int'(len) - 1; i >= 0; i--) begin
            value = calc_pkg::operand_t'(32'(value) * 32'd10 + 32'(keys[4*i +: 4]));
        end
        return value;
    endfunction

    function automatic calc_pkg::operand_t model_result(input calc_pkg::operand_t a,
                                                        input calc_pkg::operand_t b,
                                                        input calc_pkg::op_code_t op);
        case (op)
            `OP_SUB: return a - b;
            `OP_MUL: return calc_pkg::operand_t'(32'(a) * 32'(b));
            default: return a + b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        checks++;
        if (actual !== want) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, actual, want, $time);
        end
    endtask

    task automatic set_row(input int idx, input int unsigned al, input logic [15:0] ak,
                           input calc_pkg::op_code_t pre, input calc_pkg::op_code_t op,
                           input int unsigned bl, input logic [15:0] bk, input logic bz,
                           input calc_pkg::operand_t exp);
        a_len[idx]     = al;
        a_keys[idx]    = ak;
        pre_op[idx]    = pre;
        row_op[idx]    = op;
        b_len[idx]     = bl;
        b_keys[idx]    = bk;
        busy_keys[idx] = bz;
        expected[idx]  = exp;
    endtask

    task automatic load_table();
        logic [15:0]        ak;
        logic [15:0]        bk;
        calc_pkg::op_code_t op;
        set_row(0, 3, 16'h0123, '0, `OP_ADD, 2, 16'h0045, 1'b0, 16'(123 + 45));
        set_row(1, 1, 16'h0005, '0, `OP_SUB, 2, 16'h0012, 1'b0, 16'(5 - 12));
        set_row(2, 3, 16'h0300, '0, `OP_MUL, 3, 16'h0300, 1'b0, 16'(300 * 300));
        set_row(3, 2, 16'h0050, 3'b110, `OP_SUB, 1, 16'h0008, 1'b0, 16'(50 - 8));
        set_row(4, 2, 16'h0042, 3'b011, `OP_MUL, 1, 16'h0003, 1'b1, 16'(42 * 3));
        set_row(5, 4, 16'h9999, '0, `OP_MUL, 4, 16'h9999, 1'b1, 16'(9999 * 9999));
        set_row(6, 1, 16'h0000, '0, `OP_SUB, 1, 16'h0001, 1'b0, 16'(0 - 1));
        for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 4; k++) begin
                ak[4*k +: 4] = 4'($urandom % 10);
                bk[4*k +: 4] = 4'($urandom % 10);
            end
            case ($urandom % 3)
                0: op = `OP_ADD;
                1: op = `OP_SUB;
                default: op = `OP_MUL;
            endcase
            set_row(r, 4, ak, '0, op, 4, bk, 1'b0,
                    model_result(key_value(ak, 4), key_value(bk, 4), op));
        end
    endtask

    task automatic wait_ready();
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                errors++;
                $display("Error: DUT still busy after %0d cycles at %0t", waited, $time);
                return;
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic press_digit(input calc_pkg::digit_t d);
        wait_ready();
        @(posedge clk);
        keypad_input <= d;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
    endtask

    // A digit offered in the middle of operand scaling must be dropped
    task automatic key_while_busy();
        @(negedge clk);
        check_value("busy", busy, 1);
        @(posedge clk);
        keypad_input <= 4'd9;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
    endtask

    task automatic press_operator(input calc_pkg::op_code_t op);
        wait_ready();
        @(posedge clk);
        operator_input <= op;
        @(posedge clk);
        operator_input <= '0;
    endtask

    task automatic press_equal(output int unsigned latency);
        int unsigned cycles;
        wait_ready();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (complete !== 1'b1) begin
            if (cycles >= WAIT_LIMIT) begin
                errors++;
                $display("Error: no complete within %0d cycles of equals", cycles);
                break;
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        latency = cycles;
    endtask

    task automatic run_row(input int r);
        int unsigned latency;
        for (int i = int'(a_len[r]) - 1; i >= 0; i--) begin
            press_digit(calc_pkg::digit_t'(a_keys[r] >> (4 * i)));
            if (i == int'(a_len[r]) - 1) begin
                @(negedge clk);
                check_value("complete", complete, 0);       // Cleared by the new digit
            end
            if (busy_keys[r]) begin
                key_while_busy();
            end
        end
        if (pre_op[r] != '0) begin
            press_operator(pre_op[r]);
        end
        press_operator(row_op[r]);
        for (int i = int'(b_len[r]) - 1; i >= 0; i--) begin
            press_digit(calc_pkg::digit_t'(b_keys[r] >> (4 * i)));
            if (busy_keys[r]) begin
                key_while_busy();
            end
        end
        press_equal(latency);
        check_value("complete latency", latency,
                    (row_op[r] == `OP_MUL) ? `MULT_ITER + 3 : 3);
        check_value("display_output", display_output, expected[r]);
        repeat (HOLD_CYCLES) @(negedge clk);
        check_value("complete", complete, 1);               // Held until the next digit
        check_value("display_output", display_output, expected[r]);
    endtask

    initial begin
        void'($urandom(32'hdb7377bd));
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        errors         = 0;
        checks         = 0;
        load_table();
        repeat (8) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_value("complete", complete, 0);
        check_value("busy", busy, 0);
        check_value("display_output", display_output, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/calc_pkg.sv
verilog/add_sub_unit.sv
verilog/seq_multiplier.sv
verilog/calc_control.sv
verilog/calc_top.sv
tb/calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the calculator testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module calc_tb -f sim.f -o calc_sim \
    && ./obj_dir/calc_sim > "$LOG" 2>&1 \
    || echo "Build or simulation stopped with an error" >> "$LOG"

cat "$LOG"

grep -q "Testbench failed" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
